// ==== recovery_defines.svh ====
// Recovery executor widths and constants
`ifndef RECOVERY_DEFINES_SVH
`define RECOVERY_DEFINES_SVH

// Queue word width
`define REC_DATA_W 32

// Command length in bytes
`define REC_LEN_W 16

// Command code width
`define REC_CMD_W 8

// Byte position inside a queue word
`define REC_BYTE_IDX_W 2

// Recovery control byte 2 value that activates the image
`define REC_IMAGE_ACTIVATE 8'h0F

`endif

// ==== recovery_cmd_pkg.sv ====
// Recovery command codes
`include "recovery_defines.svh"

package recovery_cmd_pkg;

  // Commands handled by the executor
  typedef enum logic [`REC_CMD_W-1:0] {
    CMD_DEVICE_STATUS      = 'd36,
    CMD_DEVICE_RESET       = 'd37,
    CMD_RECOVERY_CTRL      = 'd38,
    CMD_HW_STATUS          = 'd40,
    CMD_INDIRECT_FIFO_CTRL = 'd45
  } command_e;

  // Protocol byte of the device status word
  typedef enum logic [7:0] {
    PROTOCOL_OK        = 'h0,
    PROTOCOL_ERROR_CRC = 'h4
  } protocol_error_e;

endpackage

// ==== recovery_csr_pkg.sv ====
// Recovery register bank types
`include "recovery_defines.svh"

package recovery_csr_pkg;

  // Register selector, consecutive words of one register are adjacent
  typedef enum logic [7:0] {
    CSR_DEVICE_STATUS_0      = 'd0,
    CSR_DEVICE_STATUS_1      = 'd1,
    CSR_DEVICE_RESET         = 'd2,
    CSR_RECOVERY_CTRL        = 'd3,
    CSR_HW_STATUS            = 'd4,
    CSR_INDIRECT_FIFO_CTRL_0 = 'd5,
    CSR_INDIRECT_FIFO_CTRL_1 = 'd6,
    CSR_INVALID              = 'hFF
  } csr_e;

  // First word of DEVICE_STATUS
  typedef union packed {
    logic [`REC_DATA_W-1:0] raw;
    struct packed {
      logic [15:0] reason;
      logic [7:0]  protocol;
      logic [7:0]  device;
    } f;
  } device_status_u;

  // RECOVERY_CTRL, top byte unused
  typedef union packed {
    logic [`REC_DATA_W-1:0] raw;
    struct packed {
      logic [7:0] rsvd;
      logic [7:0] activate;
      logic [7:0] image_sel;
      logic [7:0] cms;
    } f;
  } recovery_ctrl_u;

endpackage

// ==== recovery_ctrl_if.sv ====
// Executor control interface
`include "recovery_defines.svh"

interface recovery_ctrl_if;
  // Strobes from the FSM
  logic load;
  logic word_done;
  logic byte_done;
  logic len_load;

  // Counter flags
  logic                       words_left_one;
  logic                       bytes_left_one;
  logic                       len_zero;
  logic [`REC_BYTE_IDX_W-1:0] byte_idx;

  // Decoded command
  recovery_csr_pkg::csr_e sel;
  logic [`REC_LEN_W-1:0]  resp_len;
  logic                   word_in_range;

  modport fsm (
    output load, word_done, byte_done, len_load,
    input  words_left_one, bytes_left_one, len_zero, byte_idx
  );

  modport counter (
    input  load, word_done, byte_done, len_load, resp_len,
    output words_left_one, bytes_left_one, len_zero, byte_idx
  );

  modport decode (
    input  load, word_done, byte_done, byte_idx,
    output sel, resp_len, word_in_range
  );

  modport bank (
    input load, word_done, byte_idx, sel, word_in_range
  );
endinterface

// ==== recovery_fsm.sv ====
// Recovery command state machine
module recovery_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic cmd_valid_i,
  input  logic cmd_is_rd_i,
  input  logic cmd_error_i,
  input  logic rx_ack_i,
  input  logic res_ready_i,
  input  logic res_dready_i,
  output logic cmd_done_o,
  output logic res_valid_o,
  output logic res_dvalid_o,
  output logic res_dlast_o,
  output logic rx_req_o,
  output logic rx_queue_clr_o,
  output logic status_we_o,
  recovery_ctrl_if.fsm ctrl
);

  typedef enum logic [2:0] {
    Idle,
    Write,
    Read,
    ReadLen,
    ReadData,
    Error,
    Done
  } state_e;

  state_e state_q, state_d;
  logic   req_q;
  logic   pend_q;
  logic   gap_q;

  assign ctrl.load      = (state_q == Idle) && cmd_valid_i;
  // Acks only count against an outstanding request
  assign ctrl.word_done = (state_q == Write) && pend_q && rx_ack_i;
  assign ctrl.len_load  = (state_q == Read);
  assign ctrl.byte_done = res_dvalid_o && res_dready_i;

  assign rx_req_o       = req_q && !ctrl.len_zero;
  assign rx_queue_clr_o = (state_q == Error);
  assign res_valid_o    = (state_q == ReadLen);
  // One idle cycle at each word boundary while the bank reloads its word
  assign res_dvalid_o   = (state_q == ReadData) && !gap_q;
  assign res_dlast_o    = res_dvalid_o && ctrl.bytes_left_one;
  assign cmd_done_o     = (state_q == Done);
  assign status_we_o    = (state_q == Done);

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (cmd_error_i) state_d = Error;
          else if (cmd_is_rd_i) state_d = Read;
          else state_d = Write;
        end
      end
      Write: begin
        if (ctrl.len_zero || (ctrl.word_done && ctrl.words_left_one)) state_d = Done;
      end
      Read:    state_d = ReadLen;
      ReadLen: begin
        if (res_ready_i) state_d = ReadData;
      end
      ReadData: begin
        if (ctrl.byte_done && ctrl.bytes_left_one) state_d = Done;
      end
      Error:   state_d = Done;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      req_q   <= 1'b0;
      pend_q  <= 1'b0;
      gap_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // First request after acceptance, then one per ack except the last
      req_q   <= (ctrl.load && !cmd_is_rd_i && !cmd_error_i) ||
                 (ctrl.word_done && !ctrl.words_left_one);
      pend_q  <= rx_req_o || (pend_q && !rx_ack_i);
      gap_q   <= ctrl.byte_done && (ctrl.byte_idx == '1) && !ctrl.bytes_left_one;
    end
  end

  // Only one queue request in flight
  a_single_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_req_o |-> !pend_q);

  // Data phase is entered only through an accepted length
  a_len_before_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (res_dvalid_o && !$past(state_q == ReadData)) |-> $past(res_valid_o && res_ready_i));

endmodule

// ==== recovery_counter.sv ====
// Word and byte countdowns
`include "recovery_defines.svh"

module recovery_counter (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic [`REC_LEN_W-1:0] cmd_len_i,
  recovery_ctrl_if.counter     ctrl
);

  logic [`REC_LEN_W-2:0]      wcnt_q;
  logic [`REC_LEN_W-2:0]      words;
  logic [`REC_LEN_W-1:0]      bcnt_q;
  logic [`REC_BYTE_IDX_W-1:0] idx_q;

  // Length in bytes rounded up to whole words
  assign words = (`REC_LEN_W-1)'(cmd_len_i >> `REC_BYTE_IDX_W) +
                 (`REC_LEN_W-1)'(|cmd_len_i[`REC_BYTE_IDX_W-1:0]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wcnt_q <= '0;
      bcnt_q <= '0;
      idx_q  <= '0;
    end else begin
      if (ctrl.load) begin
        wcnt_q <= words;
        idx_q  <= '0;
      end else if (ctrl.word_done) begin
        wcnt_q <= wcnt_q - 1'b1;
      end
      if (ctrl.len_load) bcnt_q <= ctrl.resp_len;
      else if (ctrl.byte_done) begin
        bcnt_q <= bcnt_q - 1'b1;
        idx_q  <= idx_q + 1'b1;
      end
    end
  end

  assign ctrl.words_left_one = (wcnt_q == 1);
  assign ctrl.len_zero       = (wcnt_q == 0);
  assign ctrl.bytes_left_one = (bcnt_q == 1);
  assign ctrl.byte_idx       = idx_q;

  // FSM never consumes past the end of a countdown
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl.word_done -> wcnt_q != '0) && (ctrl.byte_done -> bcnt_q != '0));

endmodule

// ==== recovery_cmd_decode.sv ====
// Command to register decode
`include "recovery_defines.svh"

module recovery_cmd_decode (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic [`REC_CMD_W-1:0] cmd_cmd_i,
  recovery_ctrl_if.decode      ctrl
);

  recovery_csr_pkg::csr_e sel_q, sel_d;
  logic [`REC_LEN_W-1:0]  len_q, len_d;
  logic [1:0]             words_q, words_d;
  logic [1:0]             wr_cnt_q;
  logic                   rd_step;

  // Register table; words_d counts writable words only
  always_comb begin
    case (cmd_cmd_i)
      recovery_cmd_pkg::CMD_DEVICE_STATUS: begin
        sel_d = recovery_csr_pkg::CSR_DEVICE_STATUS_0;
        len_d = 'd8;
        words_d = 2'd0;
      end
      recovery_cmd_pkg::CMD_DEVICE_RESET: begin
        sel_d = recovery_csr_pkg::CSR_DEVICE_RESET;
        len_d = 'd3;
        words_d = 2'd1;
      end
      recovery_cmd_pkg::CMD_RECOVERY_CTRL: begin
        sel_d = recovery_csr_pkg::CSR_RECOVERY_CTRL;
        len_d = 'd3;
        words_d = 2'd1;
      end
      recovery_cmd_pkg::CMD_HW_STATUS: begin
        sel_d = recovery_csr_pkg::CSR_HW_STATUS;
        len_d = 'd4;
        words_d = 2'd0;
      end
      recovery_cmd_pkg::CMD_INDIRECT_FIFO_CTRL: begin
        sel_d = recovery_csr_pkg::CSR_INDIRECT_FIFO_CTRL_0;
        len_d = 'd6;
        words_d = 2'd2;
      end
      default: begin
        sel_d = recovery_csr_pkg::CSR_INVALID;
        len_d = 'd4;
        words_d = 2'd0;
      end
    endcase
  end

  // Last byte of a read word
  assign rd_step = ctrl.byte_done && (ctrl.byte_idx == '1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q    <= recovery_csr_pkg::CSR_INVALID;
      len_q    <= '0;
      words_q  <= '0;
      wr_cnt_q <= '0;
    end else if (ctrl.load) begin
      sel_q    <= sel_d;
      len_q    <= len_d;
      words_q  <= words_d;
      wr_cnt_q <= '0;
    end else begin
      if (ctrl.word_done || rd_step) sel_q <= recovery_csr_pkg::csr_e'(sel_q + 8'd1);
      // Saturates so long writes never wrap back into range
      if (ctrl.word_done && (wr_cnt_q != '1)) wr_cnt_q <= wr_cnt_q + 1'b1;
    end
  end

  assign ctrl.sel           = sel_q;
  assign ctrl.resp_len      = len_q;
  assign ctrl.word_in_range = (wr_cnt_q < words_q);

endmodule

// ==== recovery_csr_bank.sv ====
// Recovery register bank
`include "recovery_defines.svh"

module recovery_csr_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`REC_DATA_W-1:0] rx_data_i,
  input  logic [`REC_DATA_W-1:0] hw_status_i,
  input  logic                   status_error_i,
  input  logic                   status_we_i,
  output logic [7:0]             res_data_o,
  output logic                   image_activated_o,
  recovery_ctrl_if.bank          ctrl
);

  recovery_csr_pkg::device_status_u dev_status_q;
  recovery_csr_pkg::recovery_ctrl_u rec_ctrl_q;
  logic [`REC_DATA_W-1:0]           dev_reset_q;
  logic [`REC_DATA_W-1:0]           fifo_ctrl_0_q;
  logic [`REC_DATA_W-1:0]           fifo_ctrl_1_q;
  logic [`REC_DATA_W-1:0]           rd_word_q;
  logic                             err_q;
  logic                             wr_en;

  assign wr_en = ctrl.word_done && ctrl.word_in_range;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_status_q  <= '0;
      rec_ctrl_q    <= '0;
      dev_reset_q   <= '0;
      fifo_ctrl_0_q <= '0;
      fifo_ctrl_1_q <= '0;
      err_q         <= 1'b0;
    end else begin
      if (ctrl.load) err_q <= status_error_i;
      if (wr_en) begin
        case (ctrl.sel)
          recovery_csr_pkg::CSR_DEVICE_RESET:         dev_reset_q <= rx_data_i;
          recovery_csr_pkg::CSR_RECOVERY_CTRL:        rec_ctrl_q.raw <= rx_data_i;
          recovery_csr_pkg::CSR_INDIRECT_FIFO_CTRL_0: fifo_ctrl_0_q <= rx_data_i;
          recovery_csr_pkg::CSR_INDIRECT_FIFO_CTRL_1: fifo_ctrl_1_q <= rx_data_i;
          default: ;
        endcase
      end
      // Protocol status of the finished command
      if (status_we_i) begin
        dev_status_q.f.protocol <= err_q ? recovery_cmd_pkg::PROTOCOL_ERROR_CRC
                                         : recovery_cmd_pkg::PROTOCOL_OK;
      end
    end
  end

  // Read word follows the selector by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_word_q <= '0;
    end else begin
      case (ctrl.sel)
        recovery_csr_pkg::CSR_DEVICE_STATUS_0:      rd_word_q <= dev_status_q.raw;
        recovery_csr_pkg::CSR_DEVICE_RESET:         rd_word_q <= dev_reset_q;
        recovery_csr_pkg::CSR_RECOVERY_CTRL:        rd_word_q <= rec_ctrl_q.raw;
        recovery_csr_pkg::CSR_HW_STATUS:            rd_word_q <= hw_status_i;
        recovery_csr_pkg::CSR_INDIRECT_FIFO_CTRL_0: rd_word_q <= fifo_ctrl_0_q;
        recovery_csr_pkg::CSR_INDIRECT_FIFO_CTRL_1: rd_word_q <= fifo_ctrl_1_q;
        default:                                    rd_word_q <= '0;
      endcase
    end
  end

  // Least significant byte first
  assign res_data_o = rd_word_q[{ctrl.byte_idx, 3'b000} +: 8];

  assign image_activated_o = (rec_ctrl_q.f.activate == `REC_IMAGE_ACTIVATE);

  // Decode keeps out-of-range and read-only words away from the bank
  a_wr_writable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en |-> ctrl.sel inside {recovery_csr_pkg::CSR_DEVICE_RESET,
                               recovery_csr_pkg::CSR_RECOVERY_CTRL,
                               recovery_csr_pkg::CSR_INDIRECT_FIFO_CTRL_0,
                               recovery_csr_pkg::CSR_INDIRECT_FIFO_CTRL_1});

endmodule

// ==== recovery_executor.sv ====
// Recovery command executor
`include "recovery_defines.svh"

module recovery_executor (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   cmd_valid_i,
  input  logic                   cmd_is_rd_i,
  input  logic [`REC_CMD_W-1:0]  cmd_cmd_i,
  input  logic [`REC_LEN_W-1:0]  cmd_len_i,
  input  logic                   cmd_error_i,
  input  logic                   res_ready_i,
  input  logic                   res_dready_i,
  input  logic                   rx_ack_i,
  input  logic [`REC_DATA_W-1:0] rx_data_i,
  input  logic [`REC_DATA_W-1:0] hw_status_i,
  output logic                   cmd_done_o,
  output logic                   res_valid_o,
  output logic [`REC_LEN_W-1:0]  res_len_o,
  output logic                   res_dvalid_o,
  output logic [7:0]             res_data_o,
  output logic                   res_dlast_o,
  output logic                   rx_req_o,
  output logic                   rx_queue_clr_o,
  output logic                   image_activated_o
);

  recovery_ctrl_if ctrl ();

  logic status_we;

  recovery_fsm u_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_is_rd_i    (cmd_is_rd_i),
    .cmd_error_i    (cmd_error_i),
    .rx_ack_i       (rx_ack_i),
    .res_ready_i    (res_ready_i),
    .res_dready_i   (res_dready_i),
    .cmd_done_o     (cmd_done_o),
    .res_valid_o    (res_valid_o),
    .res_dvalid_o   (res_dvalid_o),
    .res_dlast_o    (res_dlast_o),
    .rx_req_o       (rx_req_o),
    .rx_queue_clr_o (rx_queue_clr_o),
    .status_we_o    (status_we),
    .ctrl           (ctrl.fsm)
  );

  recovery_counter u_counter (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd_len_i (cmd_len_i),
    .ctrl      (ctrl.counter)
  );

  recovery_cmd_decode u_decode (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd_cmd_i (cmd_cmd_i),
    .ctrl      (ctrl.decode)
  );

  recovery_csr_bank u_bank (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rx_data_i         (rx_data_i),
    .hw_status_i       (hw_status_i),
    .status_error_i    (cmd_error_i),
    .status_we_i       (status_we),
    .res_data_o        (res_data_o),
    .image_activated_o (image_activated_o),
    .ctrl              (ctrl.bank)
  );

  assign res_len_o = ctrl.resp_len;

endmodule

// ==== tb_recovery_executor.sv ====
// Recovery executor testbench
`include "recovery_defines.svh"

module tb_recovery_executor;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          PERIOD   = 40;
  localparam int          NUM_CMDS = 300;
  localparam logic [31:0] SEED     = 32'h32b42709;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   cmd_valid_i;
  logic                   cmd_is_rd_i;
  logic [`REC_CMD_W-1:0]  cmd_cmd_i;
  logic [`REC_LEN_W-1:0]  cmd_len_i;
  logic                   cmd_error_i;
  logic                   res_ready_i;
  logic                   res_dready_i;
  logic                   rx_ack_i;
  logic [`REC_DATA_W-1:0] rx_data_i;
  logic [`REC_DATA_W-1:0] hw_status_i;
  logic                   cmd_done_o;
  logic                   res_valid_o;
  logic [`REC_LEN_W-1:0]  res_len_o;
  logic                   res_dvalid_o;
  logic [7:0]             res_data_o;
  logic                   res_dlast_o;
  logic                   rx_req_o;
  logic                   rx_queue_clr_o;
  logic                   image_activated_o;

  // Register model
  logic [`REC_DATA_W-1:0] m_dev_reset;
  logic [`REC_DATA_W-1:0] m_rec_ctrl;
  logic [`REC_DATA_W-1:0] m_fifo [2];
  logic [7:0]             m_proto;

  logic [31:0] rng_state;
  int          checks;
  int          errors;

  recovery_executor uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Response length in bytes from the command table
  function automatic int resp_length(input logic [7:0] code);
    case (code)
      recovery_cmd_pkg::CMD_DEVICE_STATUS:      return 8;
      recovery_cmd_pkg::CMD_DEVICE_RESET:       return 3;
      recovery_cmd_pkg::CMD_RECOVERY_CTRL:      return 3;
      recovery_cmd_pkg::CMD_HW_STATUS:          return 4;
      recovery_cmd_pkg::CMD_INDIRECT_FIFO_CTRL: return 6;
      default:                                  return 4;
    endcase
  endfunction

  function automatic logic [31:0] read_word(input logic [7:0] code, input int w,
                                            input logic [31:0] hw);
    case (code)
      recovery_cmd_pkg::CMD_DEVICE_STATUS:      return (w == 0) ? {16'h0, m_proto, 8'h0} : '0;
      recovery_cmd_pkg::CMD_DEVICE_RESET:       return m_dev_reset;
      recovery_cmd_pkg::CMD_RECOVERY_CTRL:      return m_rec_ctrl;
      recovery_cmd_pkg::CMD_HW_STATUS:          return hw;
      recovery_cmd_pkg::CMD_INDIRECT_FIFO_CTRL: return m_fifo[w];
      default:                                  return '0;
    endcase
  endfunction

  // Words beyond a register and read-only targets are dropped
  function automatic void apply_write(input logic [7:0] code, input int w,
                                      input logic [31:0] data);
    if (code == recovery_cmd_pkg::CMD_DEVICE_RESET && w == 0) m_dev_reset = data;
    else if (code == recovery_cmd_pkg::CMD_RECOVERY_CTRL && w == 0) m_rec_ctrl = data;
    else if (code == recovery_cmd_pkg::CMD_INDIRECT_FIFO_CTRL && w < 2) m_fifo[w] = data;
  endfunction

  task automatic byte_equals(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic len_equals(input string name, input logic [`REC_LEN_W-1:0] got,
                            input logic [`REC_LEN_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic flag_equals(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic count_equals(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  // One command with its queue model and random ready stalls
  task automatic run_command(input logic [7:0] code, input logic rd,
                             input logic [15:0] len, input logic err);
    logic [7:0]  exp_bytes [$];
    logic [31:0] hw;
    logic [31:0] word;
    logic        pending;
    logic        done;
    int          rlen;
    int          nbyte;
    int          nwords;
    int          nreq;
    int          nclr;
    int          nlen;
    int          nresp;
    int          cyc;
    int          ack_wait;
    hw = next_rand();
    rlen = resp_length(code);
    for (int n = 0; n < rlen; n++) begin
      word = read_word(code, n / 4, hw);
      exp_bytes.push_back(word[8 * (n % 4) +: 8]);
    end
    pending = 1'b0;
    done = 1'b0;
    nbyte = 0;
    nwords = 0;
    nreq = 0;
    nclr = 0;
    nlen = 0;
    nresp = 0;
    cyc = 0;
    ack_wait = 0;
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_cmd_i   <= code;
    cmd_is_rd_i <= rd;
    cmd_len_i   <= len;
    cmd_error_i <= err;
    hw_status_i <= hw;
    while (!done) begin
      @(negedge clk_i);
      if (rx_req_o) begin
        flag_equals("rx_req_o with request outstanding", pending, 1'b0);
        pending = 1'b1;
        ack_wait = int'(next_rand() % 4);
        nreq++;
      end
      if (rx_ack_i) begin
        apply_write(code, nwords, rx_data_i);
        nwords++;
      end
      if (rx_queue_clr_o) begin
        count_equals("rx_queue_clr_o cycle", cyc, 1);
        nclr++;
      end
      if (res_valid_o || res_dvalid_o) nresp++;
      if (res_valid_o && res_ready_i) begin
        len_equals("res_len_o", res_len_o, 16'(rlen));
        nlen++;
      end
      if (res_dvalid_o && res_dready_i) begin
        if (nbyte < rlen) begin
          byte_equals("res_data_o", res_data_o, exp_bytes[nbyte]);
          flag_equals("res_dlast_o", res_dlast_o, nbyte == rlen - 1);
        end else begin
          errors++;
          $display("Response sent more bytes than its length at %0t ns", $time);
        end
        nbyte++;
      end
      if (cmd_done_o) begin
        done = 1'b1;
      end else begin
        @(posedge clk_i);
        cmd_valid_i  <= 1'b0;
        res_ready_i  <= (next_rand() % 4) != 0;
        res_dready_i <= (next_rand() % 4) != 0;
        if (pending && ack_wait == 0) begin
          word = next_rand();
          // Bias towards the image activate value now and then
          if ((next_rand() % 4) == 0) word[23:16] = `REC_IMAGE_ACTIVATE;
          rx_ack_i  <= 1'b1;
          rx_data_i <= word;
          pending = 1'b0;
        end else begin
          rx_ack_i <= 1'b0;
          if (pending) ack_wait--;
        end
        cyc++;
      end
    end
    m_proto = err ? recovery_cmd_pkg::PROTOCOL_ERROR_CRC : recovery_cmd_pkg::PROTOCOL_OK;
    if (err || (!rd && len == 0)) count_equals("cmd_done_o cycle", cyc, 2);
    count_equals("rx_req_o count", nreq, (err || rd) ? 0 : (int'(len) + 3) / 4);
    count_equals("rx_queue_clr_o count", nclr, err ? 1 : 0);
    count_equals("length handshakes", nlen, (rd && !err) ? 1 : 0);
    count_equals("response bytes", nbyte, (rd && !err) ? rlen : 0);
    if (!rd || err) count_equals("response cycles", nresp, 0);
    flag_equals("image_activated_o", image_activated_o,
                m_rec_ctrl[23:16] == `REC_IMAGE_ACTIVATE);
    @(posedge clk_i);
    @(negedge clk_i);
    flag_equals("cmd_done_o after done", cmd_done_o, 1'b0);
  endtask

  initial begin
    int         pick;
    logic [7:0] code;
    rng_state = SEED;
    checks = 0;
    errors = 0;
    m_dev_reset = '0;
    m_rec_ctrl = '0;
    m_fifo[0] = '0;
    m_fifo[1] = '0;
    m_proto = '0;
    rst_ni = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_is_rd_i = 1'b0;
    cmd_cmd_i = '0;
    cmd_len_i = '0;
    cmd_error_i = 1'b0;
    res_ready_i = 1'b0;
    res_dready_i = 1'b0;
    rx_ack_i = 1'b0;
    rx_data_i = '0;
    hw_status_i = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NUM_CMDS; i++) begin
      pick = int'(next_rand() % 6);
      case (pick)
        0:       code = recovery_cmd_pkg::CMD_DEVICE_STATUS;
        1:       code = recovery_cmd_pkg::CMD_DEVICE_RESET;
        2:       code = recovery_cmd_pkg::CMD_RECOVERY_CTRL;
        3:       code = recovery_cmd_pkg::CMD_HW_STATUS;
        4:       code = recovery_cmd_pkg::CMD_INDIRECT_FIFO_CTRL;
        default: code = 8'(next_rand());
      endcase
      run_command(code, next_rand() % 2 == 1, 16'(next_rand() % 11), next_rand() % 8 == 0);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized for the longest command sequence
  initial begin
    #(NUM_CMDS * 200 * PERIOD);
    $display("Watchdog expired before all commands finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+.
recovery_cmd_pkg.sv
recovery_csr_pkg.sv
recovery_ctrl_if.sv
recovery_fsm.sv
recovery_counter.sv
recovery_cmd_decode.sv
recovery_csr_bank.sv
recovery_executor.sv
tb_recovery_executor.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_recovery_executor
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

$(BUILD_DIR)/V$(TOP): $(wildcard *.sv *.svh) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
